// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - src/reg_pkg.sv
  - src/rob_pkg.sv
  - src/rename_regfile.sv
  - src/reorder_buffer.sv
  - src/issue_ctrl.sv
  - src/rename_core.sv
  - target: test
    files:
      - verif/rename_checker.sv
      - verif/tb_rename_core.sv

// ==== flist.f ====
src/reg_pkg.sv
src/rob_pkg.sv
src/rename_regfile.sv
src/reorder_buffer.sv
src/issue_ctrl.sv
src/rename_core.sv
verif/rename_checker.sv
verif/tb_rename_core.sv

// ==== src/issue_ctrl.sv ====
module issue_ctrl
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_req,
    input  issue_req_t issue_instr,
    input  logic       rob_full,
    input  tag_t       alloc_tag,
    input  operand_t   operands,
    output logic       issue_ack,
    output operand_t   issue_operands,
    output logic       alloc,
    output logic       lookup_en,
    output issue_req_t lookup
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_resp,
        st_wait_rel
    } state_t;

    state_t state;
    tag_t   own_tag;
    logic   start;

    // a request is taken only from idle, so each one allocates once.
    assign start = (state == st_idle) && issue_req && !rob_full;

    assign alloc     = start;
    assign lookup_en = start;
    assign lookup    = issue_instr;   // the source holds it stable until ack.

    assign issue_ack = (state == st_wait_rel);

    // the register file holds its operands until the next lookup.
    always_comb begin
        issue_operands         = operands;
        issue_operands.own_tag = own_tag;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_wait_resp;
                    end
                end
                st_wait_resp: state <= st_wait_rel;   // operands land here.
                st_wait_rel: begin
                    if (!issue_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            own_tag <= alloc_tag;
        end
    end

endmodule

// ==== src/reg_pkg.sv ====
// architectural register file geometry of the RV32 integer core.
package reg_pkg;

    // data width of one architectural register.
    localparam int xlen = 32;

    // number of architectural registers, x0 included.
    localparam int num_regs = 32;

    // width of an architectural register number.
    localparam int reg_idx_w = $clog2(num_regs);

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]      reg_data_t;

    // x0 is hardwired to zero and never gets a producer.
    localparam reg_idx_t reg_zero = '0;

endpackage

// ==== src/rename_core.sv ====
module rename_core
    import rob_pkg::*;
#(
    parameter int rob_depth = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_req,
    input  issue_req_t issue_instr,
    input  wb_t        wb,
    output logic       issue_ack,
    output operand_t   issue_operands,
    output commit_t    commit
);

    logic       alloc;
    logic       lookup_en;
    logic       rob_full;
    tag_t       alloc_tag;
    issue_req_t lookup;
    operand_t   operands;

    issue_ctrl u_issue_ctrl (
        .clk            (clk),
        .rst            (rst),
        .issue_req      (issue_req),
        .issue_instr    (issue_instr),
        .rob_full       (rob_full),
        .alloc_tag      (alloc_tag),
        .operands       (operands),
        .issue_ack      (issue_ack),
        .issue_operands (issue_operands),
        .alloc          (alloc),
        .lookup_en      (lookup_en),
        .lookup         (lookup)
    );

    rename_regfile #(
        .rob_depth (rob_depth)
    ) u_rename_regfile (
        .clk       (clk),
        .rst       (rst),
        .lookup_en (lookup_en),
        .lookup    (lookup),
        .alloc_tag (alloc_tag),
        .commit    (commit),
        .operands  (operands)
    );

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) u_reorder_buffer (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_rd  (lookup.rd),
        .wb        (wb),
        .alloc_tag (alloc_tag),
        .rob_full  (rob_full),
        .commit    (commit)
    );

endmodule

// ==== src/rename_regfile.sv ====
module rename_regfile
    import reg_pkg::*;
    import rob_pkg::*;
#(
    parameter int rob_depth = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       lookup_en,
    input  issue_req_t lookup,
    input  tag_t       alloc_tag,
    input  commit_t    commit,
    output operand_t   operands
);

    // value and producer of one source operand.
    typedef struct packed {
        reg_data_t value;
        tag_t      tag;
    } src_t;

    reg_data_t regs [num_regs];
    tag_t      tags [num_regs];

    src_t src1;
    src_t src2;
    logic commit_wr;
    logic rename_ok;

    // read one source with the commit of this cycle applied first.
    function automatic src_t read_src(
        input reg_idx_t  idx,
        input reg_data_t cur_value,
        input tag_t      cur_tag,
        input commit_t   cm
    );
        src_t s;
        s.value = cur_value;
        s.tag   = cur_tag;
        if (cm.valid && (cm.rd == idx) && (idx != reg_zero)) begin
            s.value = cm.data;
            if (cur_tag == cm.tag) begin
                s.tag = no_tag;   // the producer just retired.
            end
        end
        if (s.tag != no_tag) begin
            s.value = '0;
        end
        return s;
    endfunction

    assign commit_wr = commit.valid && (commit.rd != reg_zero);

    // only tags that name a real slot may become a producer.
    assign rename_ok = lookup_en && (lookup.rd != reg_zero) &&
                       (alloc_tag != no_tag) && (alloc_tag <= tag_t'(rob_depth));

    always_comb begin
        src1 = read_src(lookup.rs1, regs[lookup.rs1], tags[lookup.rs1], commit);
        src2 = read_src(lookup.rs2, regs[lookup.rs2], tags[lookup.rs2], commit);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= no_tag;
            end
            operands <= '0;
        end else begin
            if (commit_wr) begin
                regs[commit.rd] <= commit.data;
                // a younger rename keeps its own producer.
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= no_tag;
                end
            end

            if (lookup_en) begin
                operands.value1  <= src1.value;
                operands.tag1    <= src1.tag;
                operands.value2  <= src2.value;
                operands.tag2    <= src2.tag;
                operands.own_tag <= no_tag;   // filled in by the issue side.
            end

            // sources were read above, so the rename only affects later lookups.
            if (rename_ok) begin
                tags[lookup.rd] <= alloc_tag;
            end
        end
    end

endmodule

// ==== src/reorder_buffer.sv ====
module reorder_buffer
    import reg_pkg::*;
    import rob_pkg::*;
#(
    parameter int rob_depth = 7
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    input  wb_t      wb,
    output tag_t     alloc_tag,
    output logic     rob_full,
    output commit_t  commit
);

    typedef logic [tag_w-1:0] ptr_t;

    reg_idx_t  slot_rd   [rob_depth];
    reg_data_t slot_data [rob_depth];
    logic [rob_depth-1:0] slot_done;

    ptr_t head;
    ptr_t tail;
    ptr_t count;   // occupied slots, at most rob_depth.

    logic retire;
    logic do_alloc;
    logic wb_hit;
    ptr_t wb_slot;

    function automatic ptr_t next_ptr(input ptr_t p);
        ptr_t n;
        if (p == ptr_t'(rob_depth - 1)) begin
            n = '0;
        end else begin
            n = p + ptr_t'(1);
        end
        return n;
    endfunction

    assign retire = (count != '0) && slot_done[head];

    // a slot is free again in the cycle its commit is on the port.
    assign rob_full = (count == ptr_t'(rob_depth));
    assign do_alloc = alloc && !rob_full;

    // slot k carries tag k+1, tag 0 is reserved for ready registers.
    assign alloc_tag = tag_t'(tail) + tag_t'(1);

    assign wb_slot = ptr_t'(wb.tag - tag_t'(1));
    assign wb_hit  = wb.valid && (wb.tag != no_tag) && (wb.tag <= tag_t'(rob_depth));

    always_ff @(posedge clk) begin
        if (!rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
            commit    <= '0;
        end else begin
            commit.valid <= retire;   // one cycle per retired slot.
            if (retire) begin
                commit.rd   <= slot_rd[head];
                commit.tag  <= tag_t'(head) + tag_t'(1);
                commit.data <= slot_data[head];
                slot_done[head] <= 1'b0;
                head <= next_ptr(head);
            end

            if (wb_hit) begin
                slot_done[wb_slot] <= 1'b1;
            end

            if (do_alloc) begin
                slot_done[tail] <= 1'b0;
                tail <= next_ptr(tail);
            end

            case ({do_alloc, retire})
                2'b10:   count <= count + ptr_t'(1);
                2'b01:   count <= count - ptr_t'(1);
                default: count <= count;
            endcase
        end
    end

    // destination and result of each slot.
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            slot_rd[tail] <= alloc_rd;
        end
        if (wb_hit) begin
            slot_data[wb_slot] <= wb.data;
        end
    end

endmodule

// ==== src/rob_pkg.sv ====
// tags and payloads exchanged between the issue side, the reorder buffer
// and the register file.
package rob_pkg;

    import reg_pkg::*;

    // tags are 3 bits wide, so at most seven slots can be in flight.
    localparam int tag_w = 3;

    typedef logic [tag_w-1:0] tag_t;

    // a tag of zero marks a register whose value is already in the file.
    localparam tag_t no_tag = '0;

    // one instruction as seen by the renamer.
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } issue_req_t;

    // issue response. a source with a nonzero tag carries no value.
    typedef struct packed {
        reg_data_t value1;
        tag_t      tag1;
        reg_data_t value2;
        tag_t      tag2;
        tag_t      own_tag;   // tag handed to this instruction.
    } operand_t;

    // result returned by an execution unit, in any order.
    typedef struct packed {
        logic      valid;
        tag_t      tag;
        reg_data_t data;
    } wb_t;

    // in-order retirement of one slot.
    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        tag_t      tag;
        reg_data_t data;
    } commit_t;

endpackage

// ==== verif/rename_checker.sv ====
module rename_checker
    import reg_pkg::*;
    import rob_pkg::*;
#(
    parameter int rob_depth = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  issue_req_t issue_instr,
    input  logic       issue_ack,
    input  operand_t   issue_operands,
    input  wb_t        wb,
    input  commit_t    commit,
    output int         operand_errors,
    output int         commit_errors,
    output int         flow_errors,
    output int         outstanding
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        tag_t     tag;
        reg_idx_t rd;
    } inflight_t;

    reg_data_t regs [num_regs];
    tag_t      tags [num_regs];
    reg_data_t wb_data [2**tag_w];
    inflight_t rob_q [$];   // issued and not yet committed, oldest first.
    commit_t   cm_d1;
    commit_t   cm_d2;
    tag_t      next_tag;
    logic      ack_q;

    initial begin
        operand_errors = 0;
        commit_errors  = 0;
        flow_errors    = 0;
        outstanding    = 0;
    end

    always @(posedge clk) begin
        operand_t  exp_op;
        commit_t   exp_cm;
        inflight_t head;
        int        busy;
        exp_cm = '0;
        if (!rst) begin
            foreach (regs[i]) begin
                regs[i] = '0;
                tags[i] = no_tag;
            end
            rob_q.delete();
            next_tag = tag_t'(1);
        end else begin
            if (wb.valid) begin
                wb_data[wb.tag] = wb.data;
            end
            if (commit.valid && rob_q.size() == 0) begin
                flow_errors++;
                $display("commit at %0d ns while no instruction was in flight", $time);
            end else if (commit.valid) begin
                head   = rob_q.pop_front();
                exp_cm = {1'b1, head.rd, head.tag, wb_data[head.tag]};
                if (commit !== exp_cm) begin
                    commit_errors++;
                    $display("[FAIL] %0d ns: commit %0d %0d %h, expected %0d %0d %h", $time,
                             commit.rd, commit.tag, commit.data, exp_cm.rd, exp_cm.tag,
                             exp_cm.data);
                end
            end
            // a commit seen two cycles ago was in the register file's lookup cycle.
            if (cm_d2.valid && cm_d2.rd != reg_zero) begin
                regs[cm_d2.rd] = cm_d2.data;
                if (tags[cm_d2.rd] == cm_d2.tag) begin
                    tags[cm_d2.rd] = no_tag;
                end
            end
            if (issue_ack && !ack_q) begin   // the lookup ran two cycles before ack.
                // slots that committed after the lookup cycle were still taken then.
                busy = rob_q.size() + int'(cm_d1.valid) + int'(exp_cm.valid);
                if (busy >= rob_depth) begin
                    flow_errors++;
                    $display("[FAIL] %0d ns: lookup with %0d instructions in flight", $time,
                             busy);
                end
                exp_op.tag1    = tags[issue_instr.rs1];
                exp_op.value1  = (exp_op.tag1 == no_tag) ? regs[issue_instr.rs1] : '0;
                exp_op.tag2    = tags[issue_instr.rs2];
                exp_op.value2  = (exp_op.tag2 == no_tag) ? regs[issue_instr.rs2] : '0;
                exp_op.own_tag = next_tag;
                if (issue_operands !== exp_op) begin
                    operand_errors++;
                    $display("[FAIL] %0d ns: operands %h %0d %h %0d own %0d", $time,
                             issue_operands.value1, issue_operands.tag1,
                             issue_operands.value2, issue_operands.tag2,
                             issue_operands.own_tag);
                    $display("    expected %h %0d %h %0d own %0d", exp_op.value1,
                             exp_op.tag1, exp_op.value2, exp_op.tag2, exp_op.own_tag);
                end
                if (issue_instr.rd != reg_zero) begin
                    tags[issue_instr.rd] = next_tag;
                end
                rob_q.push_back({next_tag, issue_instr.rd});
                next_tag = (next_tag == tag_t'(rob_depth)) ? tag_t'(1) : next_tag + tag_t'(1);
            end
        end
        cm_d2       = cm_d1;
        cm_d1       = exp_cm;
        ack_q       = issue_ack && rst;
        outstanding = rob_q.size();
    end

endmodule

// ==== verif/tb_rename_core.sv ====
module tb_rename_core
    import reg_pkg::*;
    import rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int rob_depth      = 7;
    localparam int num_issues     = 300;
    localparam int timeout_cycles = num_issues * 40;
    localparam int stall_limit    = 16;   // cycles ack stays low before writebacks resume.

    logic       clk;
    logic       rst;
    logic       issue_req;
    issue_req_t issue_instr;
    wb_t        wb;
    logic       issue_ack;
    operand_t   issue_operands;
    commit_t    commit;

    int operand_errors;
    int commit_errors;
    int flow_errors;
    int outstanding;
    int stall_cycles;
    int cycles;

    logic [31:0] lcg_state = 32'h389e_4644;
    logic        hold_wb;
    tag_t        next_tag;
    tag_t        pending [$];   // tags issued and not yet written back.

    rename_core #(.rob_depth (rob_depth)) u_rename_core (.*);

    rename_checker #(.rob_depth (rob_depth)) u_rename_checker (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // registers stay within x0..x15 so that dependencies come up often.
    function automatic issue_req_t random_instr();
        issue_req_t  ins;
        logic [31:0] r;
        r       = next_rand();
        ins.rs1 = reg_idx_t'(r[31:28]);
        ins.rs2 = reg_idx_t'(r[27:24]);
        ins.rd  = reg_idx_t'(r[23:20] % 4'd15) + reg_idx_t'(1);
        if (r[19:17] == 3'd0) begin
            ins.rd = reg_zero;
        end
        return ins;
    endfunction

    // the handshake is driven on rising edges and observed on falling edges.
    task automatic issue_one(input issue_req_t ins);
        @(posedge clk);
        issue_req   <= 1'b1;
        issue_instr <= ins;
        @(negedge clk);
        while (issue_ack !== 1'b1) begin
            @(negedge clk);
        end
        pending.push_back(next_tag);
        next_tag = (next_tag == tag_t'(rob_depth)) ? tag_t'(1) : next_tag + tag_t'(1);
        @(posedge clk);
        issue_req <= 1'b0;
        @(negedge clk);
        while (issue_ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic print_counts();
        $display("errors: operand %0d, commit %0d, flow %0d",
                 operand_errors, commit_errors, flow_errors);
    endtask

    // random out-of-order writebacks, paused while the ROB is being filled.
    always @(posedge clk) begin
        logic [31:0] r;
        int          idx;
        wb.valid <= 1'b0;
        if (hold_wb) begin
            stall_cycles = (issue_req && !issue_ack) ? stall_cycles + 1 : 0;
            if (stall_cycles >= stall_limit) begin
                hold_wb = 1'b0;
            end
        end else if (pending.size() > 0) begin
            r = next_rand();
            if (r[31]) begin
                idx = int'(r[30:20]) % pending.size();
                wb.valid <= 1'b1;
                wb.tag   <= pending[idx];
                wb.data  <= next_rand();
                pending.delete(idx);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        print_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst          = 1'b0;
        issue_req    = 1'b0;
        issue_instr  = '0;
        wb           = '0;
        hold_wb      = 1'b0;
        stall_cycles = 0;
        next_tag     = tag_t'(1);
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_issues; i++) begin
            if (i % 100 == 0) begin
                hold_wb      = 1'b1;   // the ROB fills up and ack must wait.
                stall_cycles = 0;
            end
            issue_one(random_instr());
        end
        hold_wb = 1'b0;
        while (pending.size() != 0 || outstanding != 0) begin
            @(negedge clk);
        end
        print_counts();
        if (operand_errors + commit_errors + flow_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
